/* hdl/adc_frontend.sv */
`timescale 1ns/1ps
// ADC input stage: pin register, inverted offset binary to signed,
// and per channel digital loopback select
module adc_frontend import rp_pkg::*; (
  input  logic             adc_clk,
  input  logic             top_rst,
  // raw ADC codes
  input  raw_t [CHN-1:0]   adc_dat_i,
  // loopback control and data
  input  logic [CHN-1:0]   loop_i,
  input  smp_pair_t        loop_dat_i,
  // sample stream
  output smp_pair_t        smp_o,
  output logic             smp_vld_o
);

////////////////////////////////////////////////////////////
// input register and code conversion
////////////////////////////////////////////////////////////

// converted samples, one per channel
smp_t adc_smp [CHN];

// lowest raw bits are unused on a 14 bit converter
// MSB passes, the rest is inverted
always_ff @(posedge adc_clk) begin
  for (int i = 0; i < CHN; i++) begin
    adc_smp[i] <= {adc_dat_i[i][RAW_W-1], ~adc_dat_i[i][RAW_W-2:RAW_W-SMP_W]};
  end
end

////////////////////////////////////////////////////////////
// valid flag
////////////////////////////////////////////////////////////

// ADC never stops, data is valid from the first register load
always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    smp_vld_o <= 1'b0;
  end else begin
    smp_vld_o <= 1'b1;
  end
end

////////////////////////////////////////////////////////////
// loopback multiplexer
////////////////////////////////////////////////////////////

// loop on: take calibrated DAC sample instead of the pins
always_comb begin
  for (int i = 0; i < CHN; i++) begin
    if (loop_i[i]) begin
      smp_o.ch[i] = loop_dat_i.ch[i];
    end else begin
      smp_o.ch[i] = adc_smp[i];
    end
  end
end

endmodule

/* hdl/dac_backend.sv */
`timescale 1ns/1ps
// DAC output stage: signed to inverted offset binary,
// both channels interleaved on one bus with channel select
module dac_backend import rp_pkg::*; (
  input  logic             adc_clk,
  input  logic             top_rst,
  // calibrated pair stream
  input  smp_pair_t        in_dat_i,
  input  logic             in_vld_i,
  output logic             in_rdy_o,
  // DAC bus
  output logic [SMP_W-1:0] dac_dat_o,
  output logic             dac_sel_o
);

// code of sample zero, mid scale
localparam logic [SMP_W-1:0] DAC_IDLE = {1'b0, {(SMP_W-1){1'b1}}};

// sign passes, magnitude bits inverted
function automatic logic [SMP_W-1:0] dac_code (input smp_t smp);
  return {smp[SMP_W-1], ~smp[SMP_W-2:0]};
endfunction

////////////////////////////////////////////////////////////
// phase and pair register
////////////////////////////////////////////////////////////

// high in the cycle before channel 0 goes out
logic      phase;
// last accepted pair, repeated when no new one comes
smp_pair_t hold;
logic      take;
// channel 0 for the next cycle
smp_t      ch0_nxt;

assign in_rdy_o = phase;
assign take     = phase & in_vld_i;
// fresh pair bypasses the hold register
assign ch0_nxt  = take ? in_dat_i.ch[0] : hold.ch[0];

////////////////////////////////////////////////////////////
// interleave
////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    phase     <= 1'b0;
    hold      <= '0;
    dac_sel_o <= 1'b0;
    dac_dat_o <= DAC_IDLE;
  end else begin
    phase     <= ~phase;
    dac_sel_o <= phase;
    if (take) begin
      hold <= in_dat_i;
    end
    // sel high with channel 0, low with channel 1
    if (phase) begin
      dac_dat_o <= dac_code(ch0_nxt);
    end else begin
      dac_dat_o <= dac_code(hold.ch[1]);
    end
  end
end

////////////////////////////////////////////////////////////
// checks
////////////////////////////////////////////////////////////

// channel select alternates once out of reset
a_sel_toggle: assert property (@(posedge adc_clk) disable iff (top_rst)
  !$past(top_rst) && !$past(top_rst, 2) |-> dac_sel_o != $past(dac_sel_o));

endmodule

/* hdl/lin_cal.sv */
`timescale 1ns/1ps
// linear calibration of a channel pair, gain then offset with saturation
// two register stages, stalled together by downstream ready
module lin_cal import rp_pkg::*; #(
  // right shift after multiply, sets unity gain
  parameter int unsigned SFT = MUL_SHIFT
) (
  input  logic      adc_clk,
  input  logic      top_rst,
  // calibration set
  input  cal_pair_t cal_i,
  // input stream
  input  smp_pair_t in_dat_i,
  input  logic      in_vld_i,
  output logic      in_rdy_o,
  // output stream
  output smp_pair_t out_dat_o,
  output logic      out_vld_o,
  input  logic      out_rdy_i
);

////////////////////////////////////////////////////////////
// local types and limits
////////////////////////////////////////////////////////////

// full product width
localparam int unsigned PRD_W = SMP_W + MUL_W;
// one guard bit for the offset add
localparam int unsigned ACC_W = PRD_W + 1;

typedef logic signed [PRD_W-1:0] prd_t;
typedef logic signed [ACC_W-1:0] acc_t;

// output range of a signed sample
localparam acc_t SMP_MAX = acc_t'(2**(SMP_W-1) - 1);
localparam acc_t SMP_MIN = acc_t'(-(2**(SMP_W-1)));

// clip to sample range
function automatic smp_t sat (input acc_t val);
  smp_t res;
  if (val > SMP_MAX) begin
    res = smp_t'(SMP_MAX);
  end else if (val < SMP_MIN) begin
    res = smp_t'(SMP_MIN);
  end else begin
    res = smp_t'(val);
  end
  return res;
endfunction

////////////////////////////////////////////////////////////
// pipeline control
////////////////////////////////////////////////////////////

// advance when output slot is empty or being read
logic adv;
// stage 1 holds a product
logic st1_vld;

assign adv      = ~out_vld_o | out_rdy_i;
assign in_rdy_o = adv;

always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    st1_vld   <= 1'b0;
    out_vld_o <= 1'b0;
  end else if (adv) begin
    st1_vld   <= in_vld_i;
    out_vld_o <= st1_vld;
  end
end

////////////////////////////////////////////////////////////
// stage 1: gain multiply
////////////////////////////////////////////////////////////

prd_t st1_prd [CHN];

// data only loads on a real transfer
always_ff @(posedge adc_clk) begin
  for (int i = 0; i < CHN; i++) begin
    if (adv && in_vld_i) begin
      st1_prd[i] <= $signed(in_dat_i.ch[i]) * $signed(cal_i.ch[i].mul);
    end
  end
end

////////////////////////////////////////////////////////////
// stage 2: shift, offset, saturate
////////////////////////////////////////////////////////////

acc_t acc [CHN];

// arithmetic shift keeps the sign
always_comb begin
  for (int i = 0; i < CHN; i++) begin
    acc[i] = acc_t'(st1_prd[i] >>> SFT) + acc_t'(cal_i.ch[i].sum);
  end
end

// output keeps last valid pair, loopback reads it
always_ff @(posedge adc_clk) begin
  for (int i = 0; i < CHN; i++) begin
    if (adv && st1_vld) begin
      out_dat_o.ch[i] <= sat(acc[i]);
    end
  end
end

////////////////////////////////////////////////////////////
// checks
////////////////////////////////////////////////////////////

// stalled output must not move
a_out_hold: assert property (@(posedge adc_clk) disable iff (top_rst)
  out_vld_o && !out_rdy_i |=> out_vld_o && $stable(out_dat_o));

endmodule

/* hdl/rp_analog_top.sv */
`timescale 1ns/1ps
// two channel analog data path in the ADC clock domain
// acquisition: pins, loopback, calibration; generation: calibration, DAC interleave
module rp_analog_top import rp_pkg::*; #(
  // calibration shift, unity gain is 1 << CAL_SFT
  parameter int unsigned CAL_SFT = MUL_SHIFT
) (
  input  logic             adc_clk,
  input  logic             top_rst,
  // ADC pins
  input  raw_t [CHN-1:0]   adc_dat_i,
  // static configuration
  input  cfg_t             cfg_i,
  // generator stream
  input  smp_pair_t        gen_dat_i,
  input  logic             gen_vld_i,
  output logic             gen_rdy_o,
  // acquisition stream
  output smp_pair_t        adc_dat_o,
  output logic             adc_vld_o,
  input  logic             adc_rdy_i,
  // DAC bus
  output logic [SMP_W-1:0] dac_dat_o,
  output logic             dac_sel_o
);

////////////////////////////////////////////////////////////
// local signals
////////////////////////////////////////////////////////////

// ADC samples after loopback mux
smp_pair_t adc_smp;
logic      adc_smp_vld;

// generator into DAC calibration
logic      gen_cal_vld;
logic      gen_cal_rdy;

// calibrated DAC pairs, also the loopback source
smp_pair_t dac_smp;
logic      dac_smp_vld;
logic      dac_rdy;

////////////////////////////////////////////////////////////
// acquisition path
////////////////////////////////////////////////////////////

adc_frontend adc_fe0 (
  .adc_clk    (adc_clk),
  .top_rst    (top_rst),
  .adc_dat_i  (adc_dat_i),
  .loop_i     (cfg_i.loop),
  .loop_dat_i (dac_smp),
  .smp_o      (adc_smp),
  .smp_vld_o  (adc_smp_vld)
);

// free running source, samples offered during a stall are dropped
lin_cal #(
  .SFT (CAL_SFT)
) adc_cal0 (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .cal_i     (cfg_i.adc_cal),
  .in_dat_i  (adc_smp),
  .in_vld_i  (adc_smp_vld),
  .in_rdy_o  (),
  .out_dat_o (adc_dat_o),
  .out_vld_o (adc_vld_o),
  .out_rdy_i (adc_rdy_i)
);

////////////////////////////////////////////////////////////
// generation path
////////////////////////////////////////////////////////////

// pairs enter only in the DAC take phase
// so each one reaches the interleaver two cycles later, in phase again
assign gen_cal_vld = gen_vld_i & dac_rdy;
assign gen_rdy_o   = gen_cal_rdy & dac_rdy;

lin_cal #(
  .SFT (CAL_SFT)
) dac_cal0 (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .cal_i     (cfg_i.dac_cal),
  .in_dat_i  (gen_dat_i),
  .in_vld_i  (gen_cal_vld),
  .in_rdy_o  (gen_cal_rdy),
  .out_dat_o (dac_smp),
  .out_vld_o (dac_smp_vld),
  .out_rdy_i (dac_rdy)
);

// one pair every two cycles onto the shared bus
dac_backend dac_be0 (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .in_dat_i  (dac_smp),
  .in_vld_i  (dac_smp_vld),
  .in_rdy_o  (dac_rdy),
  .dac_dat_o (dac_dat_o),
  .dac_sel_o (dac_sel_o)
);

endmodule

/* hdl/rp_pkg.sv */
// analog data path shared definitions
// widths, sample and calibration types, static configuration
package rp_pkg;

  //////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////

  // number of analog channels
  localparam int unsigned CHN = 2;
  // useful sample bits
  localparam int unsigned SMP_W = 14;
  // raw ADC pins, bits 15:2 carry the sample
  localparam int unsigned RAW_W = 16;
  // calibration gain width
  localparam int unsigned MUL_W = 16;
  // gain 16'h2000 is unity
  localparam int unsigned MUL_SHIFT = 13;

  //////////////////////////////////////////////////////////
  // sample types
  //////////////////////////////////////////////////////////

  // raw code as seen on the ADC pins
  typedef logic [RAW_W-1:0] raw_t;

  // signed two's complement sample
  typedef logic signed [SMP_W-1:0] smp_t;

  // one sample per channel, ch[0] and ch[1]
  typedef struct packed {
    smp_t [CHN-1:0] ch;
  } smp_pair_t;

  //////////////////////////////////////////////////////////
  // calibration and configuration
  //////////////////////////////////////////////////////////

  // gain and offset for one channel
  typedef struct packed {
    logic signed [MUL_W-1:0] mul;
    logic signed [SMP_W-1:0] sum;
  } cal_t;

  // per channel calibration set
  typedef struct packed {
    cal_t [CHN-1:0] ch;
  } cal_pair_t;

  // static settings, changed only while idle
  typedef struct packed {
    // acquisition side calibration
    cal_pair_t adc_cal;
    // generation side calibration
    cal_pair_t dac_cal;
    // digital loopback enable per channel
    logic [CHN-1:0] loop;
  } cfg_t;

endpackage

/* rp_analog_top.f */
hdl/rp_pkg.sv
hdl/adc_frontend.sv
hdl/lin_cal.sv
hdl/dac_backend.sv
hdl/rp_analog_top.sv
tests/tb_clk_gen.sv
tests/tb_rp_analog_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the analog path testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f rp_analog_top.f \
  --top-module tb_rp_analog_top \
  -o sim_tb

# the log decides pass or fail, not the exit code
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

/* tests/tb_clk_gen.sv */
`timescale 1ns/1ps
// testbench clock source
// free running square wave starting low
module tb_clk_gen #(
  // full clock period in ns
  parameter int PERIOD_NS = 40
) (
  output logic clk_o = 1'b0
);

// half period high, half period low
initial begin
  forever begin
    #(PERIOD_NS / 2) clk_o = ~clk_o;
  end
end

endmodule

/* tests/tb_rp_analog_top.sv */
`timescale 1ns/1ps
// testbench for the two channel analog path
// reference model for ADC conversion, calibration, back-pressure, DAC interleave, loopback
module tb_rp_analog_top import rp_pkg::*; ();

////////////////////////////////////////////////////////////
// run length and watchdog limit
////////////////////////////////////////////////////////////

localparam int CYC_NS     = 40;
// reset, conversion, 8 settings, back-pressure, DAC, loopback
localparam int TEST_CYC   = 4 + 64 + 8 * 10 + 100 + 100 + 40;
localparam int TIMEOUT_NS = (TEST_CYC + 200) * CYC_NS;

typedef struct {
  int unsigned due;
  smp_pair_t   pr;
} dac_exp_t;

logic             adc_clk;
logic             top_rst;
raw_t [CHN-1:0]   adc_dat;
cfg_t             cfg;
smp_pair_t        gen_dat;
logic             gen_vld;
logic             gen_rdy;
smp_pair_t        adc_dat_o;
logic             adc_vld;
logic             adc_rdy;
logic [SMP_W-1:0] dac_dat;
logic             dac_sel;

// shared between stimulus and compare process
smp_pair_t   exp_q [$];
dac_exp_t    dac_q [$];
smp_pair_t   exp_const;
logic        seq_on = 1'b0;
logic        const_on = 1'b0;
logic        gen_took = 1'b0;
string       test_name = "reset";
int unsigned pcnt = 0;
int unsigned n_chk = 0;
int unsigned n_dac = 0;

tb_clk_gen #(.PERIOD_NS(CYC_NS)) clk0 (.clk_o(adc_clk));

rp_analog_top #(.CAL_SFT(MUL_SHIFT)) dut0 (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .adc_dat_i (adc_dat),
  .cfg_i     (cfg),
  .gen_dat_i (gen_dat),
  .gen_vld_i (gen_vld),
  .gen_rdy_o (gen_rdy),
  .adc_dat_o (adc_dat_o),
  .adc_vld_o (adc_vld),
  .adc_rdy_i (adc_rdy),
  .dac_dat_o (dac_dat),
  .dac_sel_o (dac_sel)
);

////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////

// msb kept, bits 14:2 inverted
function automatic smp_t adc_conv(input raw_t raw);
  return {raw[15], ~raw[14:2]};
endfunction

// gain, arithmetic shift, offset, clip to 14 bits
function automatic smp_t cal(input smp_t s, input cal_t c);
  longint p;
  p = longint'(s) * longint'(c.mul);
  p = p >>> MUL_SHIFT;
  p = p + longint'(c.sum);
  if (p > 8191) begin
    p = 8191;
  end else if (p < -8192) begin
    p = -8192;
  end
  return smp_t'(p);
endfunction

function automatic smp_pair_t cal_pair(input smp_pair_t d, input cal_pair_t c);
  smp_pair_t r;
  for (int i = 0; i < CHN; i++) begin
    r.ch[i] = cal(d.ch[i], c.ch[i]);
  end
  return r;
endfunction

// sign kept, lower 13 bits inverted
function automatic logic [SMP_W-1:0] dac_code(input smp_t s);
  return {s[13], ~s[12:0]};
endfunction

function automatic cal_t rand_cal();
  cal_t c;
  c.mul = 16'($urandom);
  c.sum = 14'($urandom);
  return c;
endfunction

task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
  $display("FAIL %s expected %h actual %h", name, exp_v, act_v);
  $display("TB FAILED");
  $fatal(1, "stopped at first mismatch");
endtask

task automatic report_error(input string msg);
  $display("error: %s", msg);
  $display("TB FAILED");
  $fatal(1, "stopped at first error");
endtask

task automatic check_reset_state();
  assert (!adc_vld) else report_mismatch("reset adc_vld_o", 64'(0), 64'(adc_vld));
  assert (!gen_rdy) else report_mismatch("reset gen_rdy_o", 64'(0), 64'(gen_rdy));
  assert (!dac_sel) else report_mismatch("reset dac_sel_o", 64'(0), 64'(dac_sel));
  assert (dac_dat == 14'h1fff)
    else report_mismatch("reset dac_dat_o", 64'(14'h1fff), 64'(dac_dat));
endtask

////////////////////////////////////////////////////////////
// compare process reading values settled since the last edge
////////////////////////////////////////////////////////////

logic      stall_prev = 1'b0;
smp_pair_t prev_dat;
logic      prev_sel = 1'b0;
smp_pair_t held;
logic      held_ok = 1'b0;

always @(posedge adc_clk) begin
  dac_exp_t         ent;
  logic [SMP_W-1:0] exp_code;
  if (!top_rst) begin
    pcnt++;
    // sequence check against the code driven 3 cycles earlier
    if (seq_on && exp_q.size() == 4) begin
      assert (adc_vld) else report_error("adc_vld_o low during conversion test");
      assert (adc_dat_o == exp_q[0])
        else report_mismatch(test_name, 64'(exp_q[0]), 64'(adc_dat_o));
      void'(exp_q.pop_front());
      n_chk++;
    end
    // with constant input every transfer must match
    if (const_on && adc_vld && adc_rdy) begin
      assert (adc_dat_o == exp_const)
        else report_mismatch(test_name, 64'(exp_const), 64'(adc_dat_o));
      n_chk++;
    end
    if (stall_prev) begin
      assert (adc_vld && adc_dat_o == prev_dat)
        else report_error("acquisition output changed while stalled");
    end
    stall_prev = adc_vld && !adc_rdy;
    prev_dat   = adc_dat_o;
    // select alternates from the third edge on
    if (pcnt >= 3) begin
      assert (dac_sel != prev_sel) else report_error("dac_sel_o did not toggle");
    end
    prev_sel = dac_sel;
    if (dac_q.size() > 0 && dac_q[0].due == pcnt) begin
      held    = dac_q[0].pr;
      held_ok = 1'b1;
      void'(dac_q.pop_front());
      n_dac++;
      assert (dac_sel) else report_error("channel 0 code arrived with dac_sel_o low");
    end
    // held pair repeats until a new one lands
    if (held_ok) begin
      exp_code = dac_sel ? dac_code(held.ch[0]) : dac_code(held.ch[1]);
      assert (dac_dat == exp_code)
        else report_mismatch("dac_interleave", 64'(exp_code), 64'(dac_dat));
    end
    gen_took = gen_vld && gen_rdy;
    if (gen_took) begin
      ent.due = pcnt + 3;
      ent.pr  = cal_pair(gen_dat, cfg.dac_cal);
      dac_q.push_back(ent);
    end
  end
end

////////////////////////////////////////////////////////////
// stimulus driven on the falling edge
////////////////////////////////////////////////////////////

task automatic drain_gen();
  while (gen_vld && !gen_took) begin
    @(negedge adc_clk);
  end
  gen_vld = 1'b0;
  repeat (8) @(negedge adc_clk);
endtask

initial begin
  smp_pair_t tmp;
  void'($urandom(32'h7222));
  top_rst = 1'b1;
  adc_dat = '0;
  gen_dat = '0;
  gen_vld = 1'b0;
  adc_rdy = 1'b1;
  cfg     = '0;
  for (int i = 0; i < CHN; i++) begin
    cfg.adc_cal.ch[i].mul = 16'sh2000;
    cfg.dac_cal.ch[i].mul = 16'sh2000;
  end

  // test 1 reset state while held and just after release
  repeat (4) begin
    @(negedge adc_clk);
    check_reset_state();
  end
  top_rst = 1'b0;
  check_reset_state();

  // test 2 conversion with unity gain
  test_name = "adc_conv";
  exp_q.delete();
  seq_on = 1'b1;
  repeat (60) begin
    @(negedge adc_clk);
    for (int i = 0; i < CHN; i++) begin
      adc_dat[i] = raw_t'($urandom);
      tmp.ch[i]  = adc_conv(adc_dat[i]);
    end
    exp_q.push_back(cal_pair(tmp, cfg.adc_cal));
  end
  seq_on = 1'b0;

  // test 3 gain and offset
  // first two settings saturate high then low
  test_name = "gain_offset";
  for (int s = 0; s < 8; s++) begin
    @(negedge adc_clk);
    for (int i = 0; i < CHN; i++) begin
      if (s == 0) begin
        cfg.adc_cal.ch[i].mul = 16'sh7fff;
        cfg.adc_cal.ch[i].sum = 14'sh1fff;
        adc_dat[i] = 16'h0000;
      end else if (s == 1) begin
        cfg.adc_cal.ch[i].mul = 16'sh8000;
        cfg.adc_cal.ch[i].sum = 14'sh2000;
        adc_dat[i] = 16'h0000;
      end else begin
        cfg.adc_cal.ch[i] = rand_cal();
        adc_dat[i] = raw_t'($urandom);
      end
      tmp.ch[i] = adc_conv(adc_dat[i]);
    end
    repeat (4) @(negedge adc_clk);
    exp_const = cal_pair(tmp, cfg.adc_cal);
    const_on  = 1'b1;
    repeat (4) @(negedge adc_clk);
    const_on  = 1'b0;
  end

  // test 4 random ready on the acquisition stream
  test_name = "backpressure";
  // fresh codes every cycle so a stalled stage holds a distinct value
  repeat (30) begin
    @(negedge adc_clk);
    adc_rdy = 1'($urandom);
    for (int i = 0; i < CHN; i++) begin
      adc_dat[i] = raw_t'($urandom);
    end
  end
  @(negedge adc_clk);
  adc_rdy = 1'b1;
  for (int i = 0; i < CHN; i++) begin
    cfg.adc_cal.ch[i] = rand_cal();
    adc_dat[i] = raw_t'($urandom);
    tmp.ch[i]  = adc_conv(adc_dat[i]);
  end
  repeat (4) @(negedge adc_clk);
  exp_const = cal_pair(tmp, cfg.adc_cal);
  const_on  = 1'b1;
  repeat (60) begin
    @(negedge adc_clk);
    adc_rdy = 1'($urandom);
  end
  @(negedge adc_clk);
  adc_rdy  = 1'b1;
  const_on = 1'b0;

  // test 5 generator pairs with valid held until taken
  test_name = "dac_interleave";
  for (int i = 0; i < CHN; i++) begin
    cfg.dac_cal.ch[i] = rand_cal();
  end
  repeat (80) begin
    @(negedge adc_clk);
    if (!gen_vld || gen_took) begin
      gen_vld = 1'($urandom);
      for (int i = 0; i < CHN; i++) begin
        gen_dat.ch[i] = smp_t'($urandom);
      end
    end
  end
  drain_gen();

  // test 6 loopback of both lanes from the DAC side
  test_name = "loopback";
  cfg.loop = 2'b11;
  for (int i = 0; i < CHN; i++) begin
    cfg.adc_cal.ch[i] = rand_cal();
    cfg.dac_cal.ch[i] = rand_cal();
    gen_dat.ch[i]     = smp_t'($urandom);
  end
  gen_vld = 1'b1;
  repeat (12) @(negedge adc_clk);
  exp_const = cal_pair(cal_pair(gen_dat, cfg.dac_cal), cfg.adc_cal);
  const_on  = 1'b1;
  repeat (10) @(negedge adc_clk);
  const_on  = 1'b0;
  drain_gen();

  assert (n_chk > 0 && n_dac > 0) else report_error("no transfers were checked");
  $display("TB PASSED");
  $finish;
end

// watchdog limit from the summed test lengths
initial begin
  #(TIMEOUT_NS);
  $display("error: watchdog timeout, tests did not complete");
  $display("TB FAILED");
  $fatal(1, "watchdog timeout");
end

endmodule
